//--- rv_retire.f
rv_retire_pkg.sv
load_extract.sv
lrsc_reservation.sv
writeback_merge.sv
retire_unit.sv
tb_retire_unit.sv

//--- Makefile
# Verilator build and run of the retire and write-back testbench

VERILATOR ?= verilator
TOP       ?= tb_retire_unit
FILELIST  ?= rv_retire.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/1ps
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# the binary is rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- tb_retire_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the retire and write-back top level
// table of beats with expected write-back, a driver loop,
// a monitor with stall checks, random back-pressure, timeout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_retire_unit
    import rv_retire_pkg::*;
();

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 4;

    // one table entry is the offered beat plus what should come out
    typedef struct packed {
        retire_req_t req;
        word_t       exp_data;
        logic        exp_we;
    } vector_t;

    logic        clk = 1'b0;
    logic        reset_n = 1'b0;
    retire_req_t req_i = '0;
    logic        req_valid_i = 1'b0;
    logic        req_ready_o;
    wb_t         wb_o;
    logic        wb_valid_o;
    logic        wb_ready_i = 1'b0;

    vector_t     table_q[$];
    int          n_entries = 0;
    int          timeout_limit = 0;
    int          cycle_count = 0;
    int          errors = 0;
    int          beats_seen = 0;
    integer      seed = 12886;
    logic        accepted;
    logic        stalled = 1'b0;
    logic        accept_seen = 1'b0;
    logic        reset_checked = 1'b0;
    wb_t         held_wb = '0;

    retire_unit UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .wb_o        (wb_o),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i)
    );

    always #HALF_PERIOD clk = ~clk;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic add_entry(input op_e op, input reg_addr_t rd, input word_t result,
                             input word_t mem_data, input word_t exp_data, input logic exp_we);
        vector_t v;
        v.req.op       = op;
        v.req.rd       = rd;
        v.req.result   = result;
        v.req.mem_data = mem_data;
        v.exp_data     = exp_data;
        v.exp_we       = exp_we;
        table_q.push_back(v);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s at %0t: got 0x%0h, expected 0x%0h",
                     name, $time, actual, expected);
        end
    endtask

    // rd only means something when the beat writes a register
    task automatic compare_beat(input int idx);
        vector_t v;
        v = table_q[idx];
        check_value($sformatf("wb_o.we[%0d]", idx), 64'(wb_o.we), 64'(v.exp_we));
        check_value($sformatf("wb_o.data[%0d]", idx), 64'(wb_o.data), 64'(v.exp_data));
        if (v.exp_we) begin
            check_value($sformatf("wb_o.rd[%0d]", idx), 64'(wb_o.rd), 64'(v.req.rd));
        end
    endtask

    // memory words used by the loads
    // 42e1359c has bytes 9c 35 e1 42, f36ad421 has bytes 21 d4 6a f3
    task automatic build_table();
        // signed bytes at every offset with the top bit set and clear
        add_entry(OP_LB,     5'd1,  32'h0000_1000, 32'h42E1_359C, 32'hFFFF_FF9C, 1'b1);
        add_entry(OP_LB,     5'd2,  32'h0000_1001, 32'h42E1_359C, 32'h0000_0035, 1'b1);
        add_entry(OP_LB,     5'd3,  32'h0000_1002, 32'h42E1_359C, 32'hFFFF_FFE1, 1'b1);
        add_entry(OP_LB,     5'd4,  32'h0000_1003, 32'h42E1_359C, 32'h0000_0042, 1'b1);
        add_entry(OP_LB,     5'd5,  32'h0000_2000, 32'hF36A_D421, 32'h0000_0021, 1'b1);
        add_entry(OP_LB,     5'd6,  32'h0000_2001, 32'hF36A_D421, 32'hFFFF_FFD4, 1'b1);
        add_entry(OP_LB,     5'd7,  32'h0000_2002, 32'hF36A_D421, 32'h0000_006A, 1'b1);
        add_entry(OP_LB,     5'd8,  32'h0000_2003, 32'hF36A_D421, 32'hFFFF_FFF3, 1'b1);
        // unsigned bytes never extend the top bit
        add_entry(OP_LBU,    5'd9,  32'h0000_1000, 32'h42E1_359C, 32'h0000_009C, 1'b1);
        add_entry(OP_LBU,    5'd10, 32'h0000_2001, 32'hF36A_D421, 32'h0000_00D4, 1'b1);
        add_entry(OP_LBU,    5'd11, 32'h0000_1002, 32'h42E1_359C, 32'h0000_00E1, 1'b1);
        add_entry(OP_LBU,    5'd12, 32'h0000_2003, 32'hF36A_D421, 32'h0000_00F3, 1'b1);
        add_entry(OP_LBU,    5'd13, 32'h0000_1001, 32'h42E1_359C, 32'h0000_0035, 1'b1);
        // half-words at both offsets
        add_entry(OP_LH,     5'd14, 32'h0000_1000, 32'h42E1_359C, 32'h0000_359C, 1'b1);
        add_entry(OP_LH,     5'd15, 32'h0000_1002, 32'h42E1_359C, 32'h0000_42E1, 1'b1);
        add_entry(OP_LH,     5'd16, 32'h0000_2000, 32'hF36A_D421, 32'hFFFF_D421, 1'b1);
        add_entry(OP_LH,     5'd17, 32'h0000_2002, 32'hF36A_D421, 32'hFFFF_F36A, 1'b1);
        add_entry(OP_LHU,    5'd18, 32'h0000_2000, 32'hF36A_D421, 32'h0000_D421, 1'b1);
        add_entry(OP_LHU,    5'd19, 32'h0000_2002, 32'hF36A_D421, 32'h0000_F36A, 1'b1);
        add_entry(OP_LHU,    5'd20, 32'h0000_1000, 32'h42E1_359C, 32'h0000_359C, 1'b1);
        add_entry(OP_LW,     5'd21, 32'h0000_1000, 32'h42E1_359C, 32'h42E1_359C, 1'b1);
        add_entry(OP_LW,     5'd22, 32'h0000_2000, 32'hF36A_D421, 32'hF36A_D421, 1'b1);
        // alu pass-through and beats that write nothing
        add_entry(OP_ALU,    5'd23, 32'hDEAD_BEEF, 32'h5A5A_5A5A, 32'hDEAD_BEEF, 1'b1);
        add_entry(OP_ALU,    5'd31, 32'h8000_0001, 32'h0000_0000, 32'h8000_0001, 1'b1);
        add_entry(OP_STORE,  5'd24, 32'h0000_3000, 32'h1111_1111, 32'h0000_0000, 1'b0);
        add_entry(OP_NOP,    5'd25, 32'h1234_5678, 32'h2222_2222, 32'h0000_0000, 1'b0);
        add_entry(OP_ALU,    5'd0,  32'hCAFE_F00D, 32'h0000_0000, 32'h0000_0000, 1'b0);
        add_entry(OP_LW,     5'd0,  32'h0000_1000, 32'h42E1_359C, 32'h0000_0000, 1'b0);
        // reservation sequence
        // SC writes 0 on success and 1 on failure
        add_entry(OP_SC_W,   5'd3,  32'h0000_0100, 32'h0000_0000, 32'h0000_0001, 1'b1);
        add_entry(OP_LR_W,   5'd4,  32'h0000_0100, 32'h55AA_33CC, 32'h55AA_33CC, 1'b1);
        add_entry(OP_SC_W,   5'd5,  32'h0000_0100, 32'h0000_0000, 32'h0000_0000, 1'b1);
        add_entry(OP_SC_W,   5'd6,  32'h0000_0100, 32'h0000_0000, 32'h0000_0001, 1'b1);
        add_entry(OP_LR_W,   5'd7,  32'h0000_0200, 32'h0BAD_F00D, 32'h0BAD_F00D, 1'b1);
        add_entry(OP_SC_W,   5'd8,  32'h0000_0204, 32'h0000_0000, 32'h0000_0001, 1'b1);
        // a store into the reserved word kills the reservation
        add_entry(OP_LR_W,   5'd9,  32'h0000_0300, 32'h7654_3210, 32'h7654_3210, 1'b1);
        add_entry(OP_STORE,  5'd10, 32'h0000_0302, 32'h0000_0000, 32'h0000_0000, 1'b0);
        add_entry(OP_SC_W,   5'd11, 32'h0000_0300, 32'h0000_0000, 32'h0000_0001, 1'b1);
        // a store elsewhere leaves it in place
        add_entry(OP_LR_W,   5'd12, 32'h0000_0400, 32'h0F0F_0F0F, 32'h0F0F_0F0F, 1'b1);
        add_entry(OP_STORE,  5'd13, 32'h0000_0500, 32'h0000_0000, 32'h0000_0000, 1'b0);
        add_entry(OP_SC_W,   5'd14, 32'h0000_0400, 32'h0000_0000, 32'h0000_0000, 1'b1);
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // back-pressure, monitor and timeout
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the consumer is not ready on roughly one cycle in three
    always @(posedge clk) begin
        #2;
        wb_ready_i = (($random(seed) % 3) != 0);
    end

    // outputs are sampled on the edge, before the registers move
    always @(posedge clk) begin
        if (reset_n) begin
            if (!reset_checked) begin
                check_value("wb_valid_o after reset", 64'(wb_valid_o), 64'd0);
                reset_checked = 1'b1;
            end
            // the input side has room unless the output is full and held
            if (wb_valid_o && !wb_ready_i) begin
                check_value("req_ready_o while full", 64'(req_ready_o), 64'd0);
            end else begin
                check_value("req_ready_o with room", 64'(req_ready_o), 64'd1);
            end
            // a beat taken on the last edge is on the output one cycle later
            if (accept_seen) begin
                check_value("wb_valid_o after accept", 64'(wb_valid_o), 64'd1);
            end
            if (stalled) begin
                check_value("wb_o while stalled", 64'(wb_o), 64'(held_wb));
            end
            if (wb_valid_o && wb_ready_i) begin
                if (beats_seen < n_entries) begin
                    compare_beat(beats_seen);
                end else begin
                    errors++;
                    $display("a write-back beat came out after the last table entry");
                end
                beats_seen++;
            end
            accept_seen = req_valid_i && req_ready_o;
            stalled     = wb_valid_o && !wb_ready_i;
            held_wb     = wb_o;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("the test timed out after %0d cycles with %0d of %0d beats seen",
                     cycle_count, beats_seen, n_entries);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // driver
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        build_table();
        n_entries     = table_q.size();
        timeout_limit = 8 * n_entries + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // each beat stays on the bus until an edge sees ready high
        for (int i = 0; i < n_entries; i++) begin
            req_i       = table_q[i].req;
            req_valid_i = 1'b1;
            accepted    = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                accepted = req_ready_o;
            end
            #2;
        end
        req_valid_i = 1'b0;
        req_i       = '0;

        // a few spare cycles show up any beat beyond the table
        wait (beats_seen == n_entries);
        repeat (4) @(posedge clk);

        $display("errors: %0d, write-back beats seen: %0d of %0d",
                 errors, beats_seen, n_entries);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- retire_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// retire and write-back top level
// load extractor and reservation tracker side by side,
// joined by the write-back merger
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module retire_unit
    import rv_retire_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // one retiring instruction per beat
    input  retire_req_t req_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,

    // one write-back beat per accepted instruction
    output wb_t         wb_o,
    output logic        wb_valid_o,
    input  logic        wb_ready_i
);

    // extracted load value for the offered beat
    word_t load_data;

    // SC.W decision for the offered beat
    logic  sc_ok;

    // beat taken in this cycle
    logic  accept;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // parallel parts
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the effective address rides in the result field, and only
    // its two low bits matter for lane selection
    load_extract u_load_extract (
        .op_i        (req_i.op),
        .addr_lsb_i  (req_i.result[1:0]),
        .mem_data_i  (req_i.mem_data),
        .load_data_o (load_data)
    );

    // the tracker sees every offered beat but only moves on accept
    lrsc_reservation u_lrsc_reservation (
        .clk      (clk),
        .reset_n  (reset_n),
        .accept_i (accept),
        .op_i     (req_i.op),
        .addr_i   (req_i.result),
        .sc_ok_o  (sc_ok)
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // merge and output stage
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    writeback_merge u_writeback_merge (
        .clk         (clk),
        .reset_n     (reset_n),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .load_data_i (load_data),
        .sc_ok_i     (sc_ok),
        .accept_o    (accept),
        .wb_o        (wb_o),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i)
    );

endmodule

//--- writeback_merge.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-back merger
// register data and write enable selection, the one-entry
// output register and the valid/ready handshake on both sides
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module writeback_merge
    import rv_retire_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // retiring instruction stream
    input  retire_req_t req_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,

    // results of the two parallel parts
    input  word_t       load_data_i,
    input  logic        sc_ok_i,

    // beat taken in this cycle, fed back to the reservation tracker
    output logic        accept_o,

    // write-back stream towards the register bank
    output wb_t         wb_o,
    output logic        wb_valid_o,
    input  logic        wb_ready_i
);

    // operation writes a register at all
    logic  op_writes;

    // data chosen by operation before the write enable is applied
    word_t sel_data;

    // next beat for the output register
    wb_t   wb_next;

    // output register
    wb_t   wb_q;
    logic  wb_valid_q;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data selection
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        unique case (req_i.op)
            // loads and LR.W take the extracted memory data
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LR_W: begin
                op_writes = 1'b1;
                sel_data  = load_data_i;
            end

            // SC.W writes its success code into rd
            OP_SC_W: begin
                op_writes = 1'b1;
                sel_data  = sc_ok_i ? SC_SUCCESS : SC_FAIL;
            end

            OP_ALU: begin
                op_writes = 1'b1;
                sel_data  = req_i.result;
            end

            // OP_STORE and OP_NOP leave the register bank untouched
            default: begin
                op_writes = 1'b0;
                sel_data  = '0;
            end
        endcase
    end

    // x0 is hardwired to zero, so a write to it is dropped
    // and a dropped write always carries zero data
    always_comb begin
        wb_next.rd   = req_i.rd;
        wb_next.we   = op_writes && (req_i.rd != '0);
        wb_next.data = wb_next.we ? sel_data : '0;
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake and output register
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // room when the register is empty or drains in this same cycle
    assign req_ready_o = !wb_valid_q || wb_ready_i;
    assign accept_o    = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_valid_q <= 1'b0;
        end else if (accept_o) begin
            wb_valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_q <= 1'b0;
        end
    end

    // payload only loads on accept, so it holds while stalled
    always_ff @(posedge clk) begin
        if (accept_o) begin
            wb_q <= wb_next;
        end
    end

    assign wb_o       = wb_q;
    assign wb_valid_o = wb_valid_q;

endmodule

//--- lrsc_reservation.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load-reserved reservation register
// and the store-conditional success decision
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module lrsc_reservation
    import rv_retire_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,

    // strobe for the beat that is taken in this cycle
    input  logic  accept_i,

    // operation and effective address of the offered beat
    input  op_e   op_i,
    input  word_t addr_i,

    // the offered SC.W would succeed
    output logic  sc_ok_o
);

    // word address of the offered beat, byte offset dropped
    logic [XLEN-1:WORD_ADDR_LSB] addr_word;

    // reservation state
    logic                        resv_valid_q;
    logic [XLEN-1:WORD_ADDR_LSB] resv_addr_q;

    // offered beat targets the reserved word
    logic                        addr_match;

    assign addr_word  = addr_i[XLEN-1:WORD_ADDR_LSB];
    assign addr_match = (resv_addr_q == addr_word);

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decision
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // combinational so that the beat now offered sees the state
    // left behind by every earlier accepted beat
    // the merger only looks at this for SC.W
    assign sc_ok_o = resv_valid_q && addr_match;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reservation update
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            resv_valid_q <= 1'b0;
            resv_addr_q  <= '0;
        end else if (accept_i) begin
            unique case (op_i)
                // a new LR.W replaces any older reservation
                OP_LR_W: begin
                    resv_valid_q <= 1'b1;
                    resv_addr_q  <= addr_word;
                end

                // every SC.W ends the reservation, whether it succeeded or not
                OP_SC_W: begin
                    resv_valid_q <= 1'b0;
                end

                // a plain store to the reserved word breaks the reservation
                // while stores to other words leave it alone
                OP_STORE: begin
                    if (addr_match) begin
                        resv_valid_q <= 1'b0;
                    end
                end

                default: begin
                    resv_valid_q <= resv_valid_q;
                end
            endcase
        end
    end

endmodule

//--- load_extract.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load data extraction from the raw memory word
// byte and half-word lane selection with sign or zero fill
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module load_extract
    import rv_retire_pkg::*;
(
    input  op_e        op_i,
    input  logic [1:0] addr_lsb_i,
    input  word_t      mem_data_i,
    output word_t      load_data_o
);

    // field picked out of the memory word before extension
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // top bit of the picked field, used for the signed forms
    logic        byte_sign;
    logic        half_sign;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane selection
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the memory word is little endian, so byte offset 0 sits in
    // the lowest eight bits and offset 3 in the highest
    always_comb begin
        unique case (addr_lsb_i)
            2'b00: byte_lane = mem_data_i[7:0];
            2'b01: byte_lane = mem_data_i[15:8];
            2'b10: byte_lane = mem_data_i[23:16];
            default: byte_lane = mem_data_i[31:24];
        endcase
    end

    // half-words only look at address bit 1
    // an odd address would be misaligned and is not trapped here
    always_comb begin
        if (addr_lsb_i[1]) begin
            half_lane = mem_data_i[31:16];
        end else begin
            half_lane = mem_data_i[15:0];
        end
    end

    assign byte_sign = byte_lane[7];
    assign half_sign = half_lane[15];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // extension
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        unique case (op_i)
            // signed byte copies bit 7 into the upper 24 bits
            OP_LB: begin
                load_data_o = {{24{byte_sign}}, byte_lane};
            end

            // unsigned byte fills with zeros
            OP_LBU: begin
                load_data_o = {24'd0, byte_lane};
            end

            // signed half-word copies bit 15 into the upper half
            OP_LH: begin
                load_data_o = {{16{half_sign}}, half_lane};
            end

            // unsigned half-word fills with zeros
            OP_LHU: begin
                load_data_o = {16'd0, half_lane};
            end

            // LW and LR.W take the whole word as it came from memory
            // for the remaining operations the merger ignores this output
            default: begin
                load_data_o = mem_data_i;
            end
        endcase
    end

endmodule

//--- rv_retire_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions of the retire and write-back subsystem
// width typedefs, the retire operation enum, the request
// and write-back beat structs, and the SC.W result values
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rv_retire_pkg;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data path width of the core
    localparam int XLEN = 32;

    // number of bits in a register index (x0 to x31)
    localparam int REG_ADDR_W = 5;

    // reservation compares work on word addresses, so the byte
    // offset bits below this position are ignored
    localparam int WORD_ADDR_LSB = 2;

    // one data or address word
    typedef logic [XLEN-1:0] word_t;

    // one register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // store-conditional results
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // SC.W writes zero into rd when the store went ahead
    localparam word_t SC_SUCCESS = 32'd0;

    // and a non-zero value when the reservation was lost
    localparam word_t SC_FAIL = 32'd1;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // retire operation
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the loads come as a group so the encodings stay contiguous
    typedef enum logic [3:0] {
        OP_ALU   = 4'd0,
        OP_LB    = 4'd1,
        OP_LBU   = 4'd2,
        OP_LH    = 4'd3,
        OP_LHU   = 4'd4,
        OP_LW    = 4'd5,
        OP_LR_W  = 4'd6,
        OP_SC_W  = 4'd7,
        OP_STORE = 4'd8,
        OP_NOP   = 4'd9
    } op_e;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // beats
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one retiring instruction as offered by the execute side
    // result holds the effective address for memory operations
    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        word_t     result;
        word_t     mem_data;
    } retire_req_t;

    // one write-back beat towards the register bank
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
        logic      we;
    } wb_t;

endpackage
